//--- source/ringBusPkg.sv
//////////////////////////////
// L1 ring bus definitions
//////////////////////////////
package ringBusPkg;

	// slot operation
	typedef enum logic [3:0] {
		idle     = 4'h0,
		loadReq  = 4'h1,  // line load, addr is line aligned
		storeReq = 4'h2,  // single word store
		loadResp = 4'h3,
		storeAck = 4'h4
	} ringOpm;

	// one ring slot, 104 bits
	typedef struct packed {
		ringOpm      opm;
		logic [1:0]  dst;   // node the message goes to
		logic [1:0]  src;   // node that sent it
		logic [31:0] addr;
		logic [63:0] data;  // whole line, or store word in the low half
	} ringMsg;

	// node ids on the ring
	localparam logic [1:0] nodeBridge = 2'd0;
	localparam logic [1:0] nodeInst   = 2'd1;
	localparam logic [1:0] nodeData   = 2'd2;

	// fault codes, bit 15 marks a critical fault
	localparam logic [15:0] faultNone      = 16'h0000;
	localparam logic [15:0] faultInstAlign = 16'h8011;
	localparam logic [15:0] faultDataAlign = 16'h8012;

	localparam ringMsg idleMsg = '{
		opm:  idle,
		dst:  2'd0,
		src:  2'd0,
		addr: 32'd0,
		data: 64'd0
	};

	// responses are consumed by the node they are addressed to
	function automatic logic isResponse(ringOpm opm);
		return (opm == loadResp) || (opm == storeAck);
	endfunction

	// byte address of the two-word line holding addr
	function automatic logic [31:0] lineBase(logic [31:0] addr);
		return {addr[31:3], 3'b000};
	endfunction

endpackage

//--- source/ringBridge.sv
//////////////////////////////
// ring to L2 bridge node
//////////////////////////////
`timescale 1ns/1ps

module ringBridge #(
	parameter logic [1:0] nodeId = ringBusPkg::nodeBridge
) (
	input  logic               clock,
	input  logic               reset,
	input  ringBusPkg::ringMsg ringIn,
	output ringBusPkg::ringMsg ringOut,
	output logic               l2Req,
	output logic               l2Write,
	output logic [31:0]        l2Addr,
	output logic [31:0]        l2WrData,
	input  logic               l2Ack,
	input  logic [31:0]        l2RdData
);
	import ringBusPkg::*;

	typedef enum logic [1:0] {
		bridgeIdle,
		bridgeReq,     // req high until ack
		bridgeAckLow,  // req dropped, wait for ack to fall
		bridgeResp     // result waits for an idle slot
	} bridgeState;

	bridgeState  state;
	logic        beat;  // word of a line load
	ringOpm      reqOpm;
	logic [1:0]  reqSrc;
	logic [31:0] reqAddr;
	logic [31:0] reqData;
	logic [63:0] lineBuf;

	logic   takeReq;
	logic   sendResp;
	ringMsg respMsg;
	ringMsg nextOut;

	// only take new work when idle, otherwise it goes round again
	assign takeReq = (state == bridgeIdle) && (ringIn.dst == nodeId) &&
		((ringIn.opm == loadReq) || (ringIn.opm == storeReq));
	assign sendResp = (state == bridgeResp) && (ringIn.opm == idle);

	assign l2Req    = (state == bridgeReq);
	assign l2Write  = (reqOpm == storeReq);
	assign l2Addr   = reqAddr + {29'd0, beat, 2'b00};
	assign l2WrData = reqData;

	always_comb
	begin
		respMsg      = idleMsg;
		respMsg.opm  = (reqOpm == storeReq) ? storeAck : loadResp;
		respMsg.dst  = reqSrc;  // back to the requester
		respMsg.src  = nodeId;
		respMsg.addr = reqAddr;
		respMsg.data = lineBuf;
	end

	always_comb
	begin
		if (sendResp)
			nextOut = respMsg;
		else if (takeReq)
			nextOut = idleMsg;
		else
			nextOut = ringIn;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state   <= bridgeIdle;
			beat    <= 1'b0;
			ringOut <= idleMsg;
		end
		else
		begin
			ringOut <= nextOut;
			case (state)
				bridgeIdle:
					if (takeReq)
					begin
						beat  <= 1'b0;
						state <= bridgeReq;
					end
				bridgeReq:
					if (l2Ack)
						state <= bridgeAckLow;
				bridgeAckLow:
					if (!l2Ack)
					begin
						if ((reqOpm == loadReq) && !beat)
						begin
							beat  <= 1'b1;  // second word of the line
							state <= bridgeReq;
						end
						else
							state <= bridgeResp;
					end
				bridgeResp:
					if (sendResp)
						state <= bridgeIdle;
				default:
					state <= bridgeIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (takeReq)
		begin
			reqOpm  <= ringIn.opm;
			reqSrc  <= ringIn.src;
			reqAddr <= ringIn.addr;
			reqData <= ringIn.data[31:0];
		end
		if ((state == bridgeReq) && l2Ack)
		begin
			if (beat)
				lineBuf[63:32] <= l2RdData;
			else
				lineBuf[31:0] <= l2RdData;
		end
	end

endmodule

//--- source/instCache.sv
//////////////////////////////
// L1 instruction cache
//////////////////////////////
`timescale 1ns/1ps

module instCache #(
	parameter int         instLines = 16,
	parameter logic [1:0] nodeId    = ringBusPkg::nodeInst
) (
	input  logic               clock,
	input  logic               reset,
	input  logic [31:0]        fetchAddr,
	input  logic               fetchValid,
	output logic [31:0]        fetchWord,
	output logic               fetchOk,
	output logic               fetchHold,
	output logic [15:0]        fetchFault,
	input  ringBusPkg::ringMsg ringIn,
	output ringBusPkg::ringMsg ringOut,
	output logic               waiting
);
	import ringBusPkg::*;

	localparam int idxBits = $clog2(instLines);
	localparam int tagBits = 29 - idxBits;

	typedef enum logic [1:0] {
		instIdle,
		instSend,  // loadReq looks for a free slot
		instWait   // loadReq is on the ring
	} instState;

	instState             state;
	logic [instLines-1:0] lineValid;
	logic [tagBits-1:0]   lineTag [instLines];
	logic [63:0]          lineData [instLines];
	logic [31:0]          reqAddr;  // held fetch address of a miss

	logic [idxBits-1:0] idx;
	logic [tagBits-1:0] tag;
	logic [idxBits-1:0] reqIdx;
	logic               accept;
	logic               misaligned;
	logic               hit;
	logic [31:0]        hitWord;
	logic               respIn;
	logic               sendReq;
	logic               fill;
	ringMsg             reqMsg;
	ringMsg             nextOut;

	assign idx        = fetchAddr[3 +: idxBits];
	assign tag        = fetchAddr[31 -: tagBits];
	assign reqIdx     = reqAddr[3 +: idxBits];
	assign accept     = fetchValid && !fetchHold;
	assign misaligned = (fetchAddr[1:0] != 2'b00);
	assign hit        = lineValid[idx] && (lineTag[idx] == tag);
	assign hitWord    = fetchAddr[2] ? lineData[idx][63:32] : lineData[idx][31:0];

	assign waiting    = (state != instIdle);
	assign fetchHold  = waiting;
	assign fetchFault = (accept && misaligned) ? faultInstAlign : faultNone;

	// ring slot handling
	assign respIn  = (ringIn.dst == nodeId) && isResponse(ringIn.opm);
	assign sendReq = (state == instSend) && ((ringIn.opm == idle) || respIn);
	assign fill    = (state == instWait) && respIn && (ringIn.opm == loadResp);

	always_comb
	begin
		reqMsg      = idleMsg;
		reqMsg.opm  = loadReq;
		reqMsg.dst  = nodeBridge;
		reqMsg.src  = nodeId;
		reqMsg.addr = lineBase(reqAddr);
		if (sendReq)
			nextOut = reqMsg;
		else if (respIn)
			nextOut = idleMsg;  // consumed
		else
			nextOut = ringIn;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= instIdle;
			fetchOk   <= 1'b0;
			lineValid <= '0;
			ringOut   <= idleMsg;
		end
		else
		begin
			ringOut <= nextOut;
			fetchOk <= 1'b0;
			case (state)
				instIdle:
					if (accept)
					begin
						if (misaligned || hit)
							fetchOk <= 1'b1;
						else
							state <= instSend;
					end
				instSend:
					if (sendReq)
						state <= instWait;
				instWait:
					if (fill)
					begin
						lineValid[reqIdx] <= 1'b1;
						fetchOk           <= 1'b1;  // same cycle hold falls
						state             <= instIdle;
					end
				default:
					state <= instIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			reqAddr   <= fetchAddr;
			fetchWord <= misaligned ? 32'd0 : hitWord;
		end
		if (fill)
		begin
			lineTag[reqIdx]  <= reqAddr[31 -: tagBits];
			lineData[reqIdx] <= ringIn.data;
			fetchWord        <= reqAddr[2] ? ringIn.data[63:32] : ringIn.data[31:0];
		end
	end

endmodule

//--- source/dataCache.sv
//////////////////////////////
// L1 data cache
//////////////////////////////
`timescale 1ns/1ps

module dataCache #(
	parameter int         dataLines = 16,
	parameter logic [1:0] nodeId    = ringBusPkg::nodeData
) (
	input  logic               clock,
	input  logic               reset,
	input  logic [31:0]        dataAddr,
	input  logic               dataValid,
	input  logic               dataWrite,
	input  logic [31:0]        dataWrData,
	output logic [31:0]        dataRdData,
	output logic               dataOk,
	output logic               dataHold,
	output logic [15:0]        dataFault,
	input  ringBusPkg::ringMsg ringIn,
	output ringBusPkg::ringMsg ringOut,
	output logic               waiting
);
	import ringBusPkg::*;

	localparam int idxBits = $clog2(dataLines);
	localparam int tagBits = 29 - idxBits;

	typedef enum logic [1:0] {
		dataIdle,
		dataSend,  // request looks for a free slot
		dataWait   // request is on the ring
	} dataState;

	dataState             state;
	logic [dataLines-1:0] lineValid;
	logic [tagBits-1:0]   lineTag [dataLines];
	logic [63:0]          lineData [dataLines];
	logic [31:0]          reqAddr;
	logic                 reqWrite;
	logic [31:0]          reqData;

	logic [idxBits-1:0] idx;
	logic [tagBits-1:0] tag;
	logic [idxBits-1:0] reqIdx;
	logic               accept;
	logic               misaligned;
	logic               hit;
	logic [31:0]        hitWord;
	logic               respIn;
	logic               sendReq;
	logic               gotResp;
	logic               fill;
	ringMsg             reqMsg;
	ringMsg             nextOut;

	assign idx        = dataAddr[3 +: idxBits];
	assign tag        = dataAddr[31 -: tagBits];
	assign reqIdx     = reqAddr[3 +: idxBits];
	assign accept     = dataValid && !dataHold;
	assign misaligned = (dataAddr[1:0] != 2'b00);
	assign hit        = lineValid[idx] && (lineTag[idx] == tag);
	assign hitWord    = dataAddr[2] ? lineData[idx][63:32] : lineData[idx][31:0];

	assign waiting   = (state != dataIdle);
	assign dataHold  = waiting;
	assign dataFault = (accept && misaligned) ? faultDataAlign : faultNone;

	assign respIn  = (ringIn.dst == nodeId) && isResponse(ringIn.opm);
	assign sendReq = (state == dataSend) && ((ringIn.opm == idle) || respIn);
	assign gotResp = (state == dataWait) && respIn;
	assign fill    = gotResp && (ringIn.opm == loadResp);

	// stores go out as a word, loads as a line
	always_comb
	begin
		reqMsg      = idleMsg;
		reqMsg.opm  = reqWrite ? storeReq : loadReq;
		reqMsg.dst  = nodeBridge;
		reqMsg.src  = nodeId;
		reqMsg.addr = reqWrite ? reqAddr : lineBase(reqAddr);
		reqMsg.data = {32'd0, reqData};
	end

	always_comb
	begin
		if (sendReq)
			nextOut = reqMsg;
		else if (respIn)
			nextOut = idleMsg;
		else
			nextOut = ringIn;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= dataIdle;
			dataOk    <= 1'b0;
			lineValid <= '0;
			ringOut   <= idleMsg;
		end
		else
		begin
			ringOut <= nextOut;
			dataOk  <= 1'b0;
			case (state)
				dataIdle:
					if (accept)
					begin
						// misaligned completes at once, no ring traffic
						if (misaligned || (!dataWrite && hit))
							dataOk <= 1'b1;
						else
							state <= dataSend;
					end
				dataSend:
					if (sendReq)
						state <= dataWait;
				dataWait:
					if (gotResp)
					begin
						if (fill)
							lineValid[reqIdx] <= 1'b1;
						dataOk <= 1'b1;
						state  <= dataIdle;
					end
				default:
					state <= dataIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			reqAddr  <= dataAddr;
			reqWrite <= dataWrite;
			reqData  <= dataWrData;
			if (!dataWrite)
				dataRdData <= misaligned ? 32'd0 : hitWord;
		end
		// write-through, store hit patches the cached word
		if (accept && dataWrite && !misaligned && hit)
		begin
			if (dataAddr[2])
				lineData[idx][63:32] <= dataWrData;
			else
				lineData[idx][31:0] <= dataWrData;
		end
		if (fill)
		begin
			lineTag[reqIdx]  <= reqAddr[31 -: tagBits];
			lineData[reqIdx] <= ringIn.data;
			dataRdData       <= reqAddr[2] ? ringIn.data[63:32] : ringIn.data[31:0];
		end
	end

endmodule

//--- source/memL1Ring.sv
//////////////////////////////
// L1 memory ring top
//////////////////////////////
`timescale 1ns/1ps

module memL1Ring #(
	parameter int instLines = 16,
	parameter int dataLines = 16
) (
	input  logic        clock,
	input  logic        reset,
	input  logic [31:0] fetchAddr,
	input  logic        fetchValid,
	output logic [31:0] fetchWord,
	output logic        fetchOk,
	output logic        fetchHold,
	input  logic [31:0] dataAddr,
	input  logic        dataValid,
	input  logic        dataWrite,
	input  logic [31:0] dataWrData,
	output logic [31:0] dataRdData,
	output logic        dataOk,
	output logic        dataHold,
	output logic        l2Req,
	output logic        l2Write,
	output logic [31:0] l2Addr,
	output logic [31:0] l2WrData,
	input  logic        l2Ack,
	input  logic [31:0] l2RdData,
	output logic [15:0] excCode,
	output logic        busWait
);
	import ringBusPkg::*;

	// ring order is bridge, data cache, instruction cache, bridge
	ringMsg      bridgeToData;
	ringMsg      dataToInst;
	ringMsg      instToBridge;
	logic [15:0] instFault;
	logic [15:0] dataFault;
	logic        instWaiting;
	logic        dataWaiting;

	ringBridge #(.nodeId(nodeBridge)) bridgeNode (
		.clock    (clock),
		.reset    (reset),
		.ringIn   (instToBridge),
		.ringOut  (bridgeToData),
		.l2Req    (l2Req),
		.l2Write  (l2Write),
		.l2Addr   (l2Addr),
		.l2WrData (l2WrData),
		.l2Ack    (l2Ack),
		.l2RdData (l2RdData)
	);

	dataCache #(.dataLines(dataLines), .nodeId(nodeData)) dataNode (
		.clock      (clock),
		.reset      (reset),
		.dataAddr   (dataAddr),
		.dataValid  (dataValid),
		.dataWrite  (dataWrite),
		.dataWrData (dataWrData),
		.dataRdData (dataRdData),
		.dataOk     (dataOk),
		.dataHold   (dataHold),
		.dataFault  (dataFault),
		.ringIn     (bridgeToData),
		.ringOut    (dataToInst),
		.waiting    (dataWaiting)
	);

	instCache #(.instLines(instLines), .nodeId(nodeInst)) instNode (
		.clock      (clock),
		.reset      (reset),
		.fetchAddr  (fetchAddr),
		.fetchValid (fetchValid),
		.fetchWord  (fetchWord),
		.fetchOk    (fetchOk),
		.fetchHold  (fetchHold),
		.fetchFault (instFault),
		.ringIn     (dataToInst),
		.ringOut    (instToBridge),
		.waiting    (instWaiting)
	);

	assign busWait = instWaiting || dataWaiting;

	// data fault wins, last fault stays until the next one
	always_ff @(posedge clock)
	begin
		if (reset)
			excCode <= faultNone;
		else if (dataFault != faultNone)
			excCode <= dataFault;
		else if (instFault != faultNone)
			excCode <= instFault;
	end

endmodule

//--- sim/l2MemModel.sv
//////////////////////////////
// L2 memory model
//////////////////////////////
`timescale 1ns/1ps

module l2MemModel (
	input  logic        clock,
	input  logic        reset,
	input  logic        req,
	input  logic        write,
	input  logic [31:0] addr,
	input  logic [31:0] wrData,
	output logic        ack,
	output logic [31:0] rdData
);
	logic [31:0] mem [logic [31:0]];  // words written so far
	integer      seed;
	int          waitLeft;  // 0 when no request is armed
	int          draw;

	initial
	begin
		seed = 96265;
	end

	// unwritten words keep the fill pattern
	function automatic logic [31:0] readWord(input logic [31:0] a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'hA5A50000;
	endfunction

	always @(posedge clock)
	begin
		if (reset)
		begin
			ack      <= 1'b0;
			rdData   <= 32'd0;
			waitLeft <= 0;
		end
		else if (ack)
		begin
			if (!req)
				ack <= 1'b0;  // back to zero
		end
		else if (req)
		begin
			if (waitLeft == 0)
				draw = 1 + int'($unsigned($random(seed)) % 32'd4);  // 1 to 4 cycles
			else
				draw = waitLeft;
			if (draw == 1)
			begin
				ack      <= 1'b1;
				waitLeft <= 0;
				rdData   <= readWord(addr);
				if (write)
					mem[addr] = wrData;
			end
			else
				waitLeft <= draw - 1;
		end
	end

endmodule

//--- sim/memL1Ring_tb.sv
//////////////////////////////
// L1 ring testbench
//////////////////////////////
`timescale 1ns/1ps

module memL1Ring_tb;
	import ringBusPkg::*;

	// about 215 accesses, none near 90 cycles
	localparam int          cycleLimit = 20000;
	localparam logic [31:0] fillMask   = 32'hA5A50000;

	logic        clock;
	logic        reset;
	logic [31:0] fetchAddr;
	logic        fetchValid;
	logic [31:0] fetchWord;
	logic        fetchOk;
	logic        fetchHold;
	logic [31:0] dataAddr;
	logic        dataValid;
	logic        dataWrite;
	logic [31:0] dataWrData;
	logic [31:0] dataRdData;
	logic        dataOk;
	logic        dataHold;
	logic        l2Req;
	logic        l2Write;
	logic [31:0] l2Addr;
	logic [31:0] l2WrData;
	logic        l2Ack;
	logic [31:0] l2RdData;
	logic [15:0] excCode;
	logic        busWait;

	logic [31:0] shadow [logic [31:0]];  // stored words
	integer      seed;
	int          cycleCount;

	memL1Ring #(.instLines(16), .dataLines(16)) i_dut (
		.clock(clock), .reset(reset),
		.fetchAddr(fetchAddr), .fetchValid(fetchValid), .fetchWord(fetchWord),
		.fetchOk(fetchOk), .fetchHold(fetchHold),
		.dataAddr(dataAddr), .dataValid(dataValid), .dataWrite(dataWrite),
		.dataWrData(dataWrData), .dataRdData(dataRdData), .dataOk(dataOk),
		.dataHold(dataHold),
		.l2Req(l2Req), .l2Write(l2Write), .l2Addr(l2Addr), .l2WrData(l2WrData),
		.l2Ack(l2Ack), .l2RdData(l2RdData),
		.excCode(excCode), .busWait(busWait)
	);

	l2MemModel l2Mem (
		.clock(clock), .reset(reset), .req(l2Req), .write(l2Write), .addr(l2Addr),
		.wrData(l2WrData), .ack(l2Ack), .rdData(l2RdData)
	);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit)
			abortRun("timeout: an access never completed");
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abortRun($sformatf("[ERROR] %s: expected %h, actual %h",
				testName, expected, actual));
	endtask

	function automatic logic [31:0] expectWord(input logic [31:0] addr);
		if (shadow.exists(addr))
			return shadow[addr];
		return addr ^ fillMask;
	endfunction

	task automatic nextCycle();
		@(posedge clock);
		#1;  // drive and sample after the edge
	endtask

	task automatic fetchAt(input logic [31:0] addr, output logic [31:0] word,
			output int latency);
		if (fetchHold)
			abortRun("fetch port still on hold before a new fetch");
		fetchAddr  = addr;
		fetchValid = 1'b1;
		nextCycle();  // accepted here
		fetchValid = 1'b0;
		latency    = 1;
		while (!fetchOk)
		begin
			checkValue("fetch hold during miss", 32'd1, 32'(fetchHold));
			nextCycle();
			latency = latency + 1;
		end
		word = fetchWord;
	endtask

	task automatic accessData(input logic write, input logic [31:0] addr,
			input logic [31:0] wrData, output logic [31:0] rdData,
			output int latency, output logic sawWait);
		if (dataHold)
			abortRun("data port still on hold before a new access");
		dataAddr   = addr;
		dataWrite  = write;
		dataWrData = wrData;
		dataValid  = 1'b1;
		nextCycle();
		dataValid = 1'b0;
		dataWrite = 1'b0;
		latency   = 1;
		sawWait   = 1'b0;
		while (!dataOk)
		begin
			checkValue("data hold while waiting", 32'd1, 32'(dataHold));
			sawWait = sawWait | busWait;
			nextCycle();
			latency = latency + 1;
		end
		rdData = dataRdData;
	endtask

	task automatic storeWord(input string testName, input logic [31:0] addr,
			input logic [31:0] value);
		logic [31:0] rd;
		int          latency;
		logic        sawWait;
		accessData(1'b1, addr, value, rd, latency, sawWait);
		checkValue({testName, " waits for ack"}, 32'd1, 32'(latency > 1));
		shadow[addr] = value;
	endtask

	task automatic loadCheck(input string testName, input logic [31:0] addr);
		logic [31:0] rd;
		int          latency;
		logic        sawWait;
		accessData(1'b0, addr, 32'd0, rd, latency, sawWait);
		checkValue(testName, expectWord(addr), rd);
	endtask

	task automatic fetchCheck(input string testName, input logic [31:0] addr);
		logic [31:0] word;
		int          latency;
		fetchAt(addr, word, latency);
		checkValue(testName, expectWord(addr), word);
	endtask

	task automatic resetState();
		checkValue("reset fetchOk", 32'd0, 32'(fetchOk));
		checkValue("reset fetchHold", 32'd0, 32'(fetchHold));
		checkValue("reset dataOk", 32'd0, 32'(dataOk));
		checkValue("reset dataHold", 32'd0, 32'(dataHold));
		checkValue("reset busWait", 32'd0, 32'(busWait));
		checkValue("reset l2Req", 32'd0, 32'(l2Req));
		checkValue("reset excCode", 32'd0, {16'd0, excCode});
	endtask

	task automatic fetchMissThenHit();
		logic [31:0] word;
		int          latency;
		fetchAt(32'h100, word, latency);
		checkValue("fetch miss word", expectWord(32'h100), word);
		checkValue("fetch miss is slow", 32'd1, 32'(latency > 1));
		fetchAt(32'h100, word, latency);
		checkValue("fetch hit word", expectWord(32'h100), word);
		checkValue("fetch hit latency", 32'd1, latency);
		fetchAt(32'h104, word, latency);  // other word of the line
		checkValue("fetch hit other word", expectWord(32'h104), word);
		checkValue("fetch hit other latency", 32'd1, latency);
	endtask

	task automatic loadMissThenHit();
		logic [31:0] rd;
		int          latency;
		logic        sawWait;
		accessData(1'b0, 32'h200, 32'd0, rd, latency, sawWait);
		checkValue("load miss word", expectWord(32'h200), rd);
		checkValue("load miss busWait", 32'd1, 32'(sawWait));
		accessData(1'b0, 32'h204, 32'd0, rd, latency, sawWait);
		checkValue("load hit word", expectWord(32'h204), rd);
		checkValue("load hit latency", 32'd1, latency);
	endtask

	task automatic storeEvictReload();
		logic [31:0] rd;
		int          latency;
		logic        sawWait;
		storeWord("store miss", 32'h240, 32'h1234_5678);
		loadCheck("load after store", 32'h240);
		storeWord("store hit", 32'h244, 32'h5A5A_1234);
		accessData(1'b0, 32'h244, 32'd0, rd, latency, sawWait);
		checkValue("load of patched word", expectWord(32'h244), rd);
		checkValue("patched word hit latency", 32'd1, latency);
		loadCheck("conflicting load", 32'h2C0);  // same index, evicts 0x240
		accessData(1'b0, 32'h240, 32'd0, rd, latency, sawWait);
		checkValue("reload after evict", expectWord(32'h240), rd);
		checkValue("reload misses", 32'd1, 32'(latency > 1));
	endtask

	task automatic dualMissRecirculate();
		logic [31:0] instWord;
		logic [31:0] loadWord;
		logic        gotFetch;
		logic        gotData;
		fetchAddr  = 32'h180;
		fetchValid = 1'b1;
		dataAddr   = 32'h1A0;
		dataWrite  = 1'b0;
		dataValid  = 1'b1;
		nextCycle();
		fetchValid = 1'b0;
		dataValid  = 1'b0;
		gotFetch   = 1'b0;
		gotData    = 1'b0;
		while (!(gotFetch && gotData))
		begin
			if (fetchOk && !gotFetch)
			begin
				instWord = fetchWord;
				gotFetch = 1'b1;
			end
			if (dataOk && !gotData)
			begin
				loadWord = dataRdData;
				gotData  = 1'b1;
			end
			if (!(gotFetch && gotData))
				nextCycle();
		end
		checkValue("dual miss fetch", expectWord(32'h180), instWord);
		checkValue("dual miss load", expectWord(32'h1A0), loadWord);
	endtask

	task automatic misalignedFaults();
		logic [31:0] rd;
		int          latency;
		logic        sawWait;
		accessData(1'b0, 32'h102, 32'd0, rd, latency, sawWait);
		checkValue("misaligned load latency", 32'd1, latency);
		checkValue("data align fault", {16'd0, faultDataAlign}, {16'd0, excCode});
		fetchAt(32'h101, rd, latency);
		checkValue("misaligned fetch latency", 32'd1, latency);
		checkValue("inst align fault", {16'd0, faultInstAlign}, {16'd0, excCode});
		loadCheck("load after faults", 32'h204);
		checkValue("fault code held", {16'd0, faultInstAlign}, {16'd0, excCode});
		// both ports fault in one cycle
		fetchAddr  = 32'h103;
		fetchValid = 1'b1;
		dataAddr   = 32'h106;
		dataWrite  = 1'b0;
		dataValid  = 1'b1;
		nextCycle();
		fetchValid = 1'b0;
		dataValid  = 1'b0;
		checkValue("both faults fetchOk", 32'd1, 32'(fetchOk));
		checkValue("both faults dataOk", 32'd1, 32'(dataOk));
		checkValue("data fault priority", {16'd0, faultDataAlign}, {16'd0, excCode});
	endtask

	task automatic randomMix();
		logic [31:0] addr;
		logic [31:0] kind;
		logic [31:0] value;
		for (int i = 0; i < 200; i++)
		begin
			addr  = $random(seed) & 32'h0000_01FC;
			kind  = $unsigned($random(seed)) % 32'd3;
			value = $random(seed);
			// icache is not coherent, so fetch only words never stored
			if ((kind == 32'd0) && !shadow.exists(addr))
				fetchCheck("random fetch", addr);
			else if (kind == 32'd1)
				storeWord("random store", addr, value);
			else
				loadCheck("random load", addr);
		end
	endtask

	initial
	begin
		seed       = 96265;
		cycleCount = 0;
		clock      = 1'b0;
		reset      = 1'b1;
		fetchAddr  = 32'd0;
		fetchValid = 1'b0;
		dataAddr   = 32'd0;
		dataValid  = 1'b0;
		dataWrite  = 1'b0;
		dataWrData = 32'd0;
		repeat (10) @(posedge clock);
		#1;
		reset = 1'b0;
		resetState();
		fetchMissThenHit();
		loadMissThenHit();
		storeEvictReload();
		dualMissRecirculate();
		misalignedFaults();
		randomMix();
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- src.f
source/ringBusPkg.sv
source/ringBridge.sv
source/instCache.sv
source/dataCache.sv
source/memL1Ring.sv
sim/l2MemModel.sv
sim/memL1Ring_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the L1 ring testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module memL1Ring_tb -o simMemL1Ring

# the search below decides pass or fail
out=$(./obj_dir/simMemL1Ring 2>&1 || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Done: no errors"
